// ==== logic/uart_pkg.sv ====
package uart_pkg;

    localparam int NUM_CHANNELS = 4;
    localparam int ADDR_WIDTH   = 32;
    localparam int DATA_WIDTH   = 32;
    localparam int CH_SEL_LSB   = 4;                  // addr[3:0] picks the register
    localparam int CH_SEL_WIDTH = 4;                  // addr[7:4] picks the channel
    localparam int CH_IDX_WIDTH = $clog2(NUM_CHANNELS);
    localparam int FIFO_DEPTH   = 8;
    localparam int BAUD_WIDTH   = 16;
    localparam int NUM_INTS     = 2;

    localparam logic [BAUD_WIDTH-1:0] BAUD_RESET_DIV = 16'd234;   // 27 MHz / 115200

    // register offsets inside one channel
    localparam logic [CH_SEL_LSB-1:0] REG_BAUD_L   = 4'd0;
    localparam logic [CH_SEL_LSB-1:0] REG_BAUD_H   = 4'd1;
    localparam logic [CH_SEL_LSB-1:0] REG_STATUS   = 4'd2;
    localparam logic [CH_SEL_LSB-1:0] REG_DATA     = 4'd3;
    localparam logic [CH_SEL_LSB-1:0] REG_INT_EN   = 4'd4;
    localparam logic [CH_SEL_LSB-1:0] REG_INT_PEND = 4'd5;

    localparam int INT_RX_READY = 0;
    localparam int INT_TX_EMPTY = 1;

    localparam int STAT_RX_READY  = 0;
    localparam int STAT_TX_FULL   = 1;
    localparam int STAT_FRAME_ERR = 2;                // flag of the head rx entry

    typedef struct packed {
        logic       frame_err;                        // stop bit sampled low
        logic [7:0] data;
    } rx_entry_t;

endpackage

// ==== logic/uart_bus_if.sv ====
`timescale 1ns/1ps

interface uart_bus_if;

    logic                                enable;      // held until ready, low between commands
    logic                                wr_en;
    logic [uart_pkg::CH_SEL_LSB-1:0]     reg_addr;
    logic [uart_pkg::DATA_WIDTH-1:0]     wdata;
    logic [uart_pkg::DATA_WIDTH/8-1:0]   be;
    logic                                ready;
    logic [uart_pkg::DATA_WIDTH-1:0]     rdata;
    logic                                err;

    modport bus (
        output enable, wr_en, reg_addr, wdata, be,
        input  ready, rdata, err
    );

    modport channel (
        input  enable, wr_en, reg_addr, wdata, be,
        output ready, rdata, err
    );

endinterface

// ==== logic/uart_fifo.sv ====
`timescale 1ns/1ps

module uart_fifo #(
    parameter type T     = logic [7:0],
    parameter int  DEPTH = uart_pkg::FIFO_DEPTH
) (
    input  logic clk,
    input  logic rst_n,
    input  logic i_push,
    input  T     i_data,
    input  logic i_pop,
    output T     o_data,
    output logic o_empty,
    output logic o_full
);

    T                         mem [DEPTH];
    logic [$clog2(DEPTH)-1:0] wr_ptr;             // wraps naturally, DEPTH is a power of two
    logic [$clog2(DEPTH)-1:0] rd_ptr;
    logic [$clog2(DEPTH):0]   count;

    assign o_data  = mem[rd_ptr];                 // head visible the cycle after a push
    assign o_empty = (count == '0);
    assign o_full  = (count == DEPTH);

    always_ff @(posedge clk) begin
        if (i_push) begin
            mem[wr_ptr] <= i_data;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (i_push) wr_ptr <= wr_ptr + 1'b1;
            if (i_pop)  rd_ptr <= rd_ptr + 1'b1;
            case ({i_push, i_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // callers must check full/empty before they strobe
    a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
        !(i_push && o_full) && !(i_pop && o_empty));

endmodule

// ==== logic/uart_tx.sv ====
`timescale 1ns/1ps

module uart_tx (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic [uart_pkg::BAUD_WIDTH-1:0] i_baud_div,
    input  logic                            i_valid,
    input  logic [7:0]                      i_data,
    output logic                            o_ready,
    output logic                            o_tx
);

    logic                            busy;
    logic [8:0]                      shift;        // data bits then the stop bit
    logic [3:0]                      bit_cnt;      // bits left after the current one
    logic [uart_pkg::BAUD_WIDTH-1:0] baud_cnt;

    assign o_ready = !busy;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy     <= 1'b0;
            shift    <= '1;
            bit_cnt  <= '0;
            baud_cnt <= '0;
            o_tx     <= 1'b1;                      // line idles high
        end else if (!busy) begin
            if (i_valid) begin
                busy     <= 1'b1;
                o_tx     <= 1'b0;                  // start bit
                shift    <= {1'b1, i_data};
                bit_cnt  <= 4'd9;
                baud_cnt <= i_baud_div;
            end
        end else if (baud_cnt != '0) begin
            baud_cnt <= baud_cnt - 1'b1;
        end else if (bit_cnt == 4'd0) begin
            busy <= 1'b0;                          // stop bit done
        end else begin
            o_tx     <= shift[0];                  // lsb first
            shift    <= {1'b1, shift[8:1]};
            bit_cnt  <= bit_cnt - 1'b1;
            baud_cnt <= i_baud_div;
        end
    end

    a_idle_high: assert property (@(posedge clk) disable iff (!rst_n)
        !busy |-> o_tx);

endmodule

// ==== logic/uart_rx.sv ====
`timescale 1ns/1ps

module uart_rx (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic [uart_pkg::BAUD_WIDTH-1:0] i_baud_div,
    input  logic                            i_rx,
    output logic                            o_valid,
    output uart_pkg::rx_entry_t             o_entry
);

    logic [1:0]                      sync;
    logic                            rx_s;
    logic                            busy;
    logic [3:0]                      bit_cnt;      // 0 start, 1..8 data, 9 stop
    logic [uart_pkg::BAUD_WIDTH-1:0] baud_cnt;
    logic [7:0]                      shift;

    assign rx_s = sync[1];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sync     <= 2'b11;
            busy     <= 1'b0;
            bit_cnt  <= '0;
            baud_cnt <= '0;
            o_valid  <= 1'b0;
        end else begin
            sync    <= {sync[0], i_rx};
            o_valid <= 1'b0;
            if (!busy) begin
                if (!rx_s) begin
                    busy     <= 1'b1;
                    bit_cnt  <= '0;
                    baud_cnt <= i_baud_div >> 1;   // half a bit to the middle of start
                end
            end else if (baud_cnt != '0) begin
                baud_cnt <= baud_cnt - 1'b1;
            end else begin
                baud_cnt <= i_baud_div;
                if (bit_cnt == 4'd0) begin
                    if (rx_s) begin
                        busy <= 1'b0;              // glitch, not a real start
                    end else begin
                        bit_cnt <= 4'd1;
                    end
                end else if (bit_cnt == 4'd9) begin
                    busy              <= 1'b0;
                    o_valid           <= 1'b1;
                    o_entry.data      <= shift;
                    o_entry.frame_err <= !rx_s;    // stop bit must read high
                end else begin
                    shift   <= {rx_s, shift[7:1]};
                    bit_cnt <= bit_cnt + 1'b1;
                end
            end
        end
    end

endmodule

// ==== logic/uart_channel.sv ====
`timescale 1ns/1ps

module uart_channel (
    input  logic               clk,
    input  logic               rst_n,
    uart_bus_if.channel        bus,
    input  logic               i_rx,
    output logic               o_tx,
    output logic               o_irq
);

    logic [uart_pkg::BAUD_WIDTH-1:0] baud_div;
    logic [uart_pkg::NUM_INTS-1:0]   int_en;
    logic [uart_pkg::NUM_INTS-1:0]   int_pend;
    logic                            retire;       // 0 issue, 1 retire

    logic                            tx_push;
    logic [7:0]                      tx_byte;
    logic [7:0]                      tx_head;
    logic                            tx_empty;
    logic                            tx_full;
    logic                            tx_ready;
    logic                            tx_empty_q;

    logic                            rx_pop;
    logic                            rx_push;
    logic                            rx_valid;
    uart_pkg::rx_entry_t             rx_entry;
    uart_pkg::rx_entry_t             rx_head;
    logic                            rx_empty;
    logic                            rx_full;
    logic                            rx_ready;
    logic                            rx_ready_q;

    assign rx_ready = !rx_empty;
    assign rx_push  = rx_valid && !rx_full;        // full rx fifo drops the byte
    assign o_irq    = |(int_en & int_pend);

    uart_fifo #(.T(logic [7:0]), .DEPTH(uart_pkg::FIFO_DEPTH)) tx_fifo_i (
        .clk(clk), .rst_n(rst_n),
        .i_push(tx_push), .i_data(tx_byte),
        .i_pop(tx_ready && !tx_empty), .o_data(tx_head),
        .o_empty(tx_empty), .o_full(tx_full)
    );

    uart_tx tx_i (
        .clk(clk), .rst_n(rst_n), .i_baud_div(baud_div),
        .i_valid(!tx_empty), .i_data(tx_head), .o_ready(tx_ready), .o_tx(o_tx)
    );

    uart_fifo #(.T(uart_pkg::rx_entry_t), .DEPTH(uart_pkg::FIFO_DEPTH)) rx_fifo_i (
        .clk(clk), .rst_n(rst_n),
        .i_push(rx_push), .i_data(rx_entry),
        .i_pop(rx_pop), .o_data(rx_head),
        .o_empty(rx_empty), .o_full(rx_full)
    );

    uart_rx rx_i (
        .clk(clk), .rst_n(rst_n), .i_baud_div(baud_div),
        .i_rx(i_rx), .o_valid(rx_valid), .o_entry(rx_entry)
    );

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            baud_div   <= uart_pkg::BAUD_RESET_DIV;
            int_en     <= '0;
            int_pend   <= '0;
            retire     <= 1'b0;
            tx_push    <= 1'b0;
            rx_pop     <= 1'b0;
            tx_empty_q <= 1'b1;
            rx_ready_q <= 1'b0;
            bus.ready  <= 1'b0;
            bus.err    <= 1'b0;
        end else begin
            tx_push <= 1'b0;                       // single cycle strobes
            rx_pop  <= 1'b0;
            if (bus.enable && !bus.ready) begin
                if (retire) begin
                    bus.ready <= 1'b1;
                end else if (!bus.be[0]) begin
                    bus.ready <= 1'b1;             // lane 0 is mandatory
                    bus.err   <= 1'b1;
                end else begin
                    retire <= 1'b1;
                    if (bus.wr_en) begin
                        case (bus.reg_addr)
                            uart_pkg::REG_BAUD_L: begin
                                if (bus.be[1]) baud_div <= bus.wdata[15:0];
                                else           baud_div[7:0] <= bus.wdata[7:0];
                            end
                            uart_pkg::REG_BAUD_H:   baud_div[15:8] <= bus.wdata[7:0];
                            uart_pkg::REG_STATUS: ;            // read only
                            uart_pkg::REG_DATA: begin
                                if (!tx_full) begin            // silently dropped when full
                                    tx_push <= 1'b1;
                                    tx_byte <= bus.wdata[7:0];
                                end
                            end
                            uart_pkg::REG_INT_EN:   int_en <= bus.wdata[uart_pkg::NUM_INTS-1:0];
                            uart_pkg::REG_INT_PEND:
                                int_pend <= int_pend & ~bus.wdata[uart_pkg::NUM_INTS-1:0];
                            default:                bus.err <= 1'b1;
                        endcase
                    end else begin
                        bus.rdata <= '0;
                        case (bus.reg_addr)
                            uart_pkg::REG_BAUD_L: begin
                                if (bus.be[1]) bus.rdata[15:0] <= baud_div;
                                else           bus.rdata[7:0]  <= baud_div[7:0];
                            end
                            uart_pkg::REG_BAUD_H:   bus.rdata[7:0] <= baud_div[15:8];
                            uart_pkg::REG_STATUS: begin
                                bus.rdata[uart_pkg::STAT_RX_READY]  <= rx_ready;
                                bus.rdata[uart_pkg::STAT_TX_FULL]   <= tx_full;
                                bus.rdata[uart_pkg::STAT_FRAME_ERR] <= rx_ready && rx_head.frame_err;
                            end
                            uart_pkg::REG_DATA: begin
                                if (rx_ready) begin
                                    bus.rdata[7:0] <= rx_head.data;
                                    rx_pop         <= 1'b1;
                                end
                            end
                            uart_pkg::REG_INT_EN:   bus.rdata[uart_pkg::NUM_INTS-1:0] <= int_en;
                            uart_pkg::REG_INT_PEND: bus.rdata[uart_pkg::NUM_INTS-1:0] <= int_pend;
                            default:                bus.err <= 1'b1;
                        endcase
                    end
                end
            end else if (!bus.enable) begin
                bus.ready <= 1'b0;                 // idle cycle rearms the machine
                bus.err   <= 1'b0;
                retire    <= 1'b0;
            end

            // pending bits latch on rising edges, a new edge beats a clear
            if (rx_ready && !rx_ready_q) int_pend[uart_pkg::INT_RX_READY] <= 1'b1;
            if (tx_empty && !tx_empty_q) int_pend[uart_pkg::INT_TX_EMPTY] <= 1'b1;
            rx_ready_q <= rx_ready;
            tx_empty_q <= tx_empty;
        end
    end

    a_ready_needs_enable: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(bus.ready) |-> $past(bus.enable));

endmodule

// ==== logic/uart_bus_split.sv ====
`timescale 1ns/1ps

module uart_bus_split (
    input  logic                                i_enable,
    input  logic                                i_wr_en,
    input  logic [uart_pkg::ADDR_WIDTH-1:0]     i_addr,
    input  logic [uart_pkg::DATA_WIDTH-1:0]     i_wdata,
    input  logic [uart_pkg::DATA_WIDTH/8-1:0]   i_be,
    uart_bus_if.bus                             ch [uart_pkg::NUM_CHANNELS],
    output logic [uart_pkg::CH_SEL_WIDTH-1:0]   o_sel,
    output logic                                o_bad_sel
);

    localparam int SEL_TOP = uart_pkg::CH_SEL_LSB + uart_pkg::CH_SEL_WIDTH;

    logic upper_set;

    assign o_sel     = i_addr[uart_pkg::CH_SEL_LSB +: uart_pkg::CH_SEL_WIDTH];
    assign upper_set = |i_addr[uart_pkg::ADDR_WIDTH-1:SEL_TOP];
    assign o_bad_sel = upper_set || (o_sel >= uart_pkg::NUM_CHANNELS);

    for (genvar i = 0; i < uart_pkg::NUM_CHANNELS; i++) begin : g_ch
        // only the addressed channel sees enable
        assign ch[i].enable   = i_enable && !o_bad_sel && (o_sel == i);
        assign ch[i].wr_en    = i_wr_en;
        assign ch[i].reg_addr = i_addr[uart_pkg::CH_SEL_LSB-1:0];
        assign ch[i].wdata    = i_wdata;
        assign ch[i].be       = i_be;
    end

endmodule

// ==== logic/uart_bus_join.sv ====
`timescale 1ns/1ps

module uart_bus_join (
    input  logic                               clk,
    input  logic                               rst_n,
    uart_bus_if.bus                            ch [uart_pkg::NUM_CHANNELS],
    input  logic [uart_pkg::CH_SEL_WIDTH-1:0]  i_sel,
    input  logic                               i_bad_sel,
    input  logic                               i_enable,
    output logic                               o_ready,
    output logic [uart_pkg::DATA_WIDTH-1:0]    o_rdata,
    output logic                               o_err
);

    logic [uart_pkg::NUM_CHANNELS-1:0] ch_ready;
    logic [uart_pkg::NUM_CHANNELS-1:0] ch_err;
    logic [uart_pkg::DATA_WIDTH-1:0]   ch_rdata [uart_pkg::NUM_CHANNELS];
    logic [uart_pkg::CH_IDX_WIDTH-1:0] idx;
    logic                              bad_resp;   // ready and err for a missing channel

    for (genvar i = 0; i < uart_pkg::NUM_CHANNELS; i++) begin : g_ch
        assign ch_ready[i] = ch[i].ready;
        assign ch_err[i]   = ch[i].err;
        assign ch_rdata[i] = ch[i].rdata;
    end

    assign idx     = i_sel[uart_pkg::CH_IDX_WIDTH-1:0];
    assign o_ready = i_bad_sel ? bad_resp : ch_ready[idx];
    assign o_err   = i_bad_sel ? bad_resp : ch_err[idx];
    assign o_rdata = i_bad_sel ? '0 : ch_rdata[idx];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            bad_resp <= 1'b0;
        end else if (!i_enable) begin
            bad_resp <= 1'b0;
        end else if (i_bad_sel) begin
            bad_resp <= 1'b1;                      // answer on the first edge
        end
    end

endmodule

// ==== logic/uart_periph_top.sv ====
`timescale 1ns/1ps

module uart_periph_top (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic                                 i_enable,
    input  logic                                 i_wr_en,
    input  logic [uart_pkg::ADDR_WIDTH-1:0]      i_addr,
    input  logic [uart_pkg::DATA_WIDTH-1:0]      i_wdata,
    input  logic [uart_pkg::DATA_WIDTH/8-1:0]    i_be,
    output logic                                 o_ready,
    output logic [uart_pkg::DATA_WIDTH-1:0]      o_rdata,
    output logic                                 o_err,
    output logic [uart_pkg::NUM_CHANNELS-1:0]    o_irq,
    input  logic [uart_pkg::NUM_CHANNELS-1:0]    i_rx,
    output logic [uart_pkg::NUM_CHANNELS-1:0]    o_tx
);

    logic [uart_pkg::CH_SEL_WIDTH-1:0] sel;
    logic                              bad_sel;

    uart_bus_if ch_bus [uart_pkg::NUM_CHANNELS] ();

    uart_bus_split split_i (
        .i_enable(i_enable), .i_wr_en(i_wr_en), .i_addr(i_addr),
        .i_wdata(i_wdata), .i_be(i_be),
        .ch(ch_bus), .o_sel(sel), .o_bad_sel(bad_sel)
    );

    for (genvar i = 0; i < uart_pkg::NUM_CHANNELS; i++) begin : g_chan
        uart_channel chan_i (
            .clk(clk), .rst_n(rst_n), .bus(ch_bus[i]),
            .i_rx(i_rx[i]), .o_tx(o_tx[i]), .o_irq(o_irq[i])
        );
    end

    uart_bus_join join_i (
        .clk(clk), .rst_n(rst_n), .ch(ch_bus),
        .i_sel(sel), .i_bad_sel(bad_sel), .i_enable(i_enable),
        .o_ready(o_ready), .o_rdata(o_rdata), .o_err(o_err)
    );

endmodule

// ==== tb/uart_periph_tb.sv ====
`timescale 1ns/1ps

module uart_periph_tb;

    localparam int NUM_CH      = uart_pkg::NUM_CHANNELS;
    localparam int RB_OPS      = 40;
    localparam int ERR_OPS     = 16;
    localparam int LOOP_FRAMES = 32;
    localparam int BATCH       = 4;                  // keeps each rx fifo far from full
    localparam int POLL_LIMIT  = 200;
    // serial frames of 10 bits at 4 cycles plus about 8 cycles for each bus command
    localparam int TIMEOUT = (LOOP_FRAMES + 1) * 10 * 4 * 4
                           + (RB_OPS * (1 + 4 * NUM_CH) + ERR_OPS * 6 + 400) * 8;

    logic              clk;
    logic              rst_n;
    logic              i_enable;
    logic              i_wr_en;
    logic [31:0]       i_addr;
    logic [31:0]       i_wdata;
    logic [3:0]        i_be;
    logic              o_ready;
    logic [31:0]       o_rdata;
    logic              o_err;
    logic [NUM_CH-1:0] o_irq;
    logic [NUM_CH-1:0] serial;                       // o_tx looped to i_rx

    logic [15:0] lfsr;
    int          errors;
    logic [15:0] m_baud [NUM_CH];
    logic [1:0]  m_int_en [NUM_CH];
    logic [1:0]  m_pend [NUM_CH];
    logic [9:0]  in_flight [$];                      // {channel, byte} in send order

    uart_periph_top dut_i (
        .clk(clk), .rst_n(rst_n), .i_enable(i_enable), .i_wr_en(i_wr_en),
        .i_addr(i_addr), .i_wdata(i_wdata), .i_be(i_be), .o_ready(o_ready),
        .o_rdata(o_rdata), .o_err(o_err), .o_irq(o_irq), .i_rx(serial), .o_tx(serial)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    // fibonacci lfsr with taps x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [31:0] lfsr_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] got);
        if (got !== exp) begin
            $display("error %s expected %h got %h", name, exp, got);
            errors++;
        end
    endtask

    // returns on a rising edge with enable low again
    task automatic bus_cycle(input logic wr, input logic [31:0] addr, input logic [31:0] wdata,
                             input logic [3:0] be, output logic [31:0] rdata, output logic err,
                             output int edges);
        int cycles;
        i_enable <= 1'b1;
        i_wr_en  <= wr;
        i_addr   <= addr;
        i_wdata  <= wdata;
        i_be     <= be;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!o_ready && cycles < 16);
        if (!o_ready) begin
            $display("bus command to address %h got no ready", addr);
            errors++;
        end
        rdata = o_rdata;
        err   = o_err;
        edges = cycles - 1;                          // rising edges that saw enable high
        @(posedge clk);
        i_enable <= 1'b0;
        @(posedge clk);
    endtask

    task automatic reg_rw(input logic wr, input int ch, input logic [3:0] off,
                          input logic [31:0] wdata, input logic [3:0] be, output logic [31:0] rd);
        logic err;
        int   edges;
        bus_cycle(wr, {24'd0, 4'(ch), off}, wdata, be, rd, err, edges);
        check_value($sformatf("ch%0d reg %0d o_err", ch, off), 32'd0, 32'(err));
        check_value($sformatf("ch%0d reg %0d o_ready edge", ch, off), 32'd2, 32'(edges));
    endtask

    task automatic poll_status(input int ch, input int bit_idx, input logic want);
        logic [31:0] st;
        int          polls;
        polls       = 0;
        st          = '0;
        st[bit_idx] = !want;
        while (st[bit_idx] != want && polls < POLL_LIMIT) begin
            reg_rw(1'b0, ch, uart_pkg::REG_STATUS, 32'd0, 4'b0001, st);
            polls++;
        end
        if (st[bit_idx] != want) begin
            $display("STATUS bit %0d of channel %0d never reached %0d", bit_idx, ch, want);
            errors++;
        end
        check_value($sformatf("ch%0d STATUS frame_err", ch), 32'd0, 32'(st[2]));
    endtask

    task automatic check_regs(input int ch);
        logic [31:0] rd;
        reg_rw(1'b0, ch, uart_pkg::REG_BAUD_L, 32'd0, 4'b0011, rd);
        check_value($sformatf("ch%0d BAUD_L rdata", ch), 32'(m_baud[ch]), rd);
        reg_rw(1'b0, ch, uart_pkg::REG_BAUD_H, 32'd0, 4'b0001, rd);
        check_value($sformatf("ch%0d BAUD_H rdata", ch), 32'(m_baud[ch][15:8]), rd);
        reg_rw(1'b0, ch, uart_pkg::REG_INT_EN, 32'd0, 4'b0001, rd);
        check_value($sformatf("ch%0d INT_EN rdata", ch), 32'(m_int_en[ch]), rd);
        reg_rw(1'b0, ch, uart_pkg::REG_INT_PEND, 32'd0, 4'b0001, rd);
        check_value($sformatf("ch%0d INT_PEND rdata", ch), 32'(m_pend[ch]), rd);
    endtask

    initial begin
        repeat (TIMEOUT) @(posedge clk);
        $display("timeout after %0d cycles, the tests did not finish", TIMEOUT);
        $display("TESTBENCH FAILED");
        $finish;
    end

    initial begin
        logic [31:0]       rd;
        logic [31:0]       data;
        logic [31:0]       addr;
        logic [3:0]        be;
        logic              err;
        logic [9:0]        ent;
        logic [NUM_CH-1:0] used;
        int                ch;
        int                waited;
        int                lat;
        int                exp_lat;
        rst_n    = 1'b0;
        i_enable = 1'b0;
        i_wr_en  = 1'b0;
        i_addr   = '0;
        i_wdata  = '0;
        i_be     = '0;
        lfsr     = 16'd47789;
        errors   = 0;
        used     = '0;
        for (int c = 0; c < NUM_CH; c++) begin
            m_baud[c]   = 16'd234;                   // divider after reset
            m_int_en[c] = '0;
            m_pend[c]   = '0;
        end
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        check_value("o_tx", 32'((1 << NUM_CH) - 1), 32'(serial));   // lines rest high
        check_value("o_irq", 32'd0, 32'(o_irq));
        check_value("o_ready o_err", 32'd0, 32'({o_ready, o_err}));
        for (int c = 0; c < NUM_CH; c++) check_regs(c);

        for (int n = 0; n < RB_OPS; n++) begin
            ch   = int'(lfsr_bits(2));
            data = lfsr_bits(16);
            be   = {2'b00, 1'(lfsr_bits(1)), 1'b1};
            case (lfsr_bits(2))
                0: begin
                    reg_rw(1'b1, ch, uart_pkg::REG_BAUD_L, data, be, rd);
                    if (be[1]) m_baud[ch] = data[15:0];
                    else m_baud[ch][7:0] = data[7:0];   // upper byte kept
                end
                1: begin
                    reg_rw(1'b1, ch, uart_pkg::REG_BAUD_H, data, be, rd);
                    m_baud[ch][15:8] = data[7:0];
                end
                default: begin
                    reg_rw(1'b1, ch, uart_pkg::REG_INT_EN, data, be, rd);
                    m_int_en[ch] = data[1:0];
                end
            endcase
            for (int c = 0; c < NUM_CH; c++) check_regs(c);
        end

        // short frames for the serial tests
        for (int c = 0; c < NUM_CH; c++) begin
            reg_rw(1'b1, c, uart_pkg::REG_BAUD_L, 32'd3, 4'b0011, rd);
            reg_rw(1'b1, c, uart_pkg::REG_INT_EN, 32'd0, 4'b0001, rd);
            m_baud[c]   = 16'd3;
            m_int_en[c] = 2'b00;
        end

        for (int n = 0; n < ERR_OPS; n++) begin
            ch      = int'(lfsr_bits(2));
            addr    = {24'd0, 4'(ch), uart_pkg::REG_DATA};
            be      = 4'b0001;
            exp_lat = 1;                                  // answered on the first edge
            case (lfsr_bits(2))
                0: be = {3'(lfsr_bits(3)), 1'b0};         // lane 0 missing
                1: addr[7:4] = 4'(4 + lfsr_bits(3));      // no such channel
                2: begin
                    addr[3:0] = 4'(6 + lfsr_bits(3));     // no such register
                    exp_lat   = 2;                        // error comes with retire
                end
                default: addr[8 + lfsr_bits(4)] = 1'b1;
            endcase
            bus_cycle(1'(lfsr_bits(1)), addr, lfsr_bits(8), be, rd, err, lat);
            check_value($sformatf("addr %h be %h o_err", addr, be), 32'd1, 32'(err));
            check_value($sformatf("addr %h be %h o_ready edge", addr, be), 32'(exp_lat), 32'(lat));
            check_regs(ch);                               // next command must succeed
        end

        for (int b = 0; b < LOOP_FRAMES / BATCH; b++) begin
            for (int n = 0; n < BATCH; n++) begin
                ch   = int'(lfsr_bits(2));
                data = lfsr_bits(8);
                poll_status(ch, uart_pkg::STAT_TX_FULL, 1'b0);
                reg_rw(1'b1, ch, uart_pkg::REG_DATA, data, 4'b0001, rd);
                in_flight.push_back({2'(ch), data[7:0]});
                used[ch] = 1'b1;
            end
            while (in_flight.size() > 0) begin
                ent = in_flight.pop_front();
                poll_status(int'(ent[9:8]), uart_pkg::STAT_RX_READY, 1'b1);
                reg_rw(1'b0, int'(ent[9:8]), uart_pkg::REG_DATA, 32'd0, 4'b0001, rd);
                check_value($sformatf("ch%0d DATA rdata", ent[9:8]), 32'(ent[7:0]), rd);
            end
            check_value("o_irq", 32'd0, 32'(o_irq));     // all enables are zero here
        end
        // both edges seen on every channel that carried a byte
        for (int c = 0; c < NUM_CH; c++) begin
            m_pend[c] = used[c] ? 2'b11 : 2'b00;
            check_regs(c);
            reg_rw(1'b1, c, uart_pkg::REG_INT_PEND, 32'd3, 4'b0001, rd);
            m_pend[c] = 2'b00;
        end

        ch   = int'(lfsr_bits(2));
        data = lfsr_bits(8);
        reg_rw(1'b1, ch, uart_pkg::REG_INT_EN, 32'd1, 4'b0001, rd);
        m_int_en[ch] = 2'b01;
        reg_rw(1'b1, ch, uart_pkg::REG_DATA, data, 4'b0001, rd);
        waited = 0;
        while (!o_irq[ch] && waited < POLL_LIMIT) begin
            @(posedge clk);
            waited++;
        end
        check_value("o_irq", 32'd1 << ch, 32'(o_irq));
        poll_status(ch, uart_pkg::STAT_RX_READY, 1'b1);
        reg_rw(1'b0, ch, uart_pkg::REG_DATA, 32'd0, 4'b0001, rd);
        check_value($sformatf("ch%0d DATA rdata", ch), data, rd);
        reg_rw(1'b1, ch, uart_pkg::REG_INT_PEND, 32'd1, 4'b0001, rd);
        check_value("o_irq", 32'd0, 32'(o_irq));
        m_pend[ch] = 2'b10;                               // tx fifo drained meanwhile
        check_regs(ch);
        reg_rw(1'b1, ch, uart_pkg::REG_INT_PEND, 32'd2, 4'b0001, rd);
        m_pend[ch] = 2'b00;
        for (int c = 0; c < NUM_CH; c++) check_regs(c);

        $display("%0d errors found", errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// ==== uart_periph.f ====
logic/uart_pkg.sv
logic/uart_bus_if.sv
logic/uart_fifo.sv
logic/uart_tx.sv
logic/uart_rx.sv
logic/uart_channel.sv
logic/uart_bus_split.sv
logic/uart_bus_join.sv
logic/uart_periph_top.sv
tb/uart_periph_tb.sv

// ==== build.sh ====
#!/bin/sh
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert -Wno-fatal --top-module uart_periph_tb \
    -f uart_periph.f -o uart_periph_sim > build.log 2>&1 \
    && ./obj_dir/uart_periph_sim > sim.log 2>&1 \
    || echo "TESTBENCH FAILED" >> sim.log
cat sim.log
grep -q "TESTBENCH FAILED" sim.log && exit 1 || exit 0
